/* Makefile */
TOP := tb_cache_cluster

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --assert -j 0 --top-module $(TOP) \
		-f compile.f -Mdir obj_dir
	-./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@grep -q "^Testbench passed$$" sim.log && echo "Simulation passed" || \
		(echo "Simulation did not pass, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

/* compile.f */
logic/cache_pkg.sv
logic/core_arb.sv
logic/cache_unit.sv
logic/mem_arb.sv
logic/cache_cluster.sv
tests/mem_model.sv
tests/tb_cache_cluster.sv

/* logic/cache_cluster.sv */
module cache_cluster (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [cache_pkg::NUM_INPUTS-1:0]                 core_req_valid,
    input  cache_pkg::core_req_t [cache_pkg::NUM_INPUTS-1:0] core_req,
    output logic [cache_pkg::NUM_INPUTS-1:0]                 core_req_ready,
    output logic [cache_pkg::NUM_INPUTS-1:0]                 core_rsp_valid,
    output cache_pkg::core_rsp_t [cache_pkg::NUM_INPUTS-1:0] core_rsp,
    input  logic [cache_pkg::NUM_INPUTS-1:0]                 core_rsp_ready,
    output logic                                             mem_req_valid,
    output cache_pkg::mem_req_t                              mem_req,
    input  logic                                             mem_req_ready,
    input  logic                                             mem_rsp_valid,
    input  cache_pkg::mem_rsp_t                              mem_rsp,
    output logic                                             mem_rsp_ready
);

    // Arbiter to cache units
    logic [cache_pkg::NUM_CACHES-1:0]                arb_req_valid;
    cache_pkg::arb_req_t [cache_pkg::NUM_CACHES-1:0] arb_req;
    logic [cache_pkg::NUM_CACHES-1:0]                arb_req_ready;
    logic [cache_pkg::NUM_CACHES-1:0]                arb_rsp_valid;
    cache_pkg::arb_rsp_t [cache_pkg::NUM_CACHES-1:0] arb_rsp;
    logic [cache_pkg::NUM_CACHES-1:0]                arb_rsp_ready;

    // Cache units to memory arbiter
    logic [cache_pkg::NUM_CACHES-1:0]                umem_req_valid;
    cache_pkg::mem_req_t [cache_pkg::NUM_CACHES-1:0] umem_req;
    logic [cache_pkg::NUM_CACHES-1:0]                umem_req_ready;
    logic [cache_pkg::NUM_CACHES-1:0]                umem_rsp_valid;
    cache_pkg::mem_rsp_t [cache_pkg::NUM_CACHES-1:0] umem_rsp;
    logic [cache_pkg::NUM_CACHES-1:0]                umem_rsp_ready;

    core_arb core_arb (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .arb_req_valid  (arb_req_valid),
        .arb_req        (arb_req),
        .arb_req_ready  (arb_req_ready),
        .arb_rsp_valid  (arb_rsp_valid),
        .arb_rsp        (arb_rsp),
        .arb_rsp_ready  (arb_rsp_ready)
    );

    for (genvar u = 0; u < cache_pkg::NUM_CACHES; u++) begin : g_cache
        cache_unit cache_unit (
            .clk           (clk),
            .rst_n         (rst_n),
            .req_valid     (arb_req_valid[u]),
            .req           (arb_req[u]),
            .req_ready     (arb_req_ready[u]),
            .rsp_valid     (arb_rsp_valid[u]),
            .rsp           (arb_rsp[u]),
            .rsp_ready     (arb_rsp_ready[u]),
            .mem_req_valid (umem_req_valid[u]),
            .mem_req       (umem_req[u]),
            .mem_req_ready (umem_req_ready[u]),
            .mem_rsp_valid (umem_rsp_valid[u]),
            .mem_rsp       (umem_rsp[u]),
            .mem_rsp_ready (umem_rsp_ready[u])
        );
    end

    mem_arb mem_arb (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (umem_req_valid),
        .req           (umem_req),
        .req_ready     (umem_req_ready),
        .rsp_valid     (umem_rsp_valid),
        .rsp           (umem_rsp),
        .rsp_ready     (umem_rsp_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

endmodule

/* logic/cache_pkg.sv */
package cache_pkg;

    // Cluster shape
    localparam int NUM_INPUTS       = 4;
    localparam int NUM_CACHES       = 2;
    localparam int INPUTS_PER_CACHE = 2;

    // Cache geometry
    localparam int LINE_WORDS       = 4;
    localparam int NUM_LINES        = 16;
    localparam int WORD_ADDR_WIDTH  = 12;

    typedef logic [31:0]                  word_t;
    typedef logic [3:0]                   byteen_t;
    // Word address is {tag[5:0], index[3:0], word[1:0]}
    typedef logic [WORD_ADDR_WIDTH-1:0]   word_addr_t;
    typedef logic [WORD_ADDR_WIDTH-3:0]   line_addr_t;
    typedef logic [LINE_WORDS*32-1:0]     line_t;
    typedef logic [LINE_WORDS*4-1:0]      line_byteen_t;
    typedef logic [7:0]                   core_tag_t;
    // Core tag with the port-within-unit bit on top
    typedef logic [8:0]                   arb_tag_t;
    typedef logic [0:0]                   unit_sel_t;

    typedef struct packed {
        logic       rw;
        byteen_t    byteen;
        word_addr_t addr;
        word_t      data;
        core_tag_t  tag;
    } core_req_t;

    typedef struct packed {
        word_t     data;
        core_tag_t tag;
    } core_rsp_t;

    typedef struct packed {
        logic       rw;
        byteen_t    byteen;
        word_addr_t addr;
        word_t      data;
        arb_tag_t   tag;
    } arb_req_t;

    typedef struct packed {
        word_t    data;
        arb_tag_t tag;
    } arb_rsp_t;

    typedef struct packed {
        logic         rw;
        line_byteen_t byteen;
        line_addr_t   addr;
        line_t        data;
        unit_sel_t    tag;
    } mem_req_t;

    typedef struct packed {
        line_t     data;
        unit_sel_t tag;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MEM_WRITE,
        MEM_READ,
        RESPOND
    } cache_state_e;

endpackage

/* logic/cache_unit.sv */
module cache_unit (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_valid,
    input  cache_pkg::arb_req_t req,
    output logic                req_ready,
    output logic                rsp_valid,
    output cache_pkg::arb_rsp_t rsp,
    input  logic                rsp_ready,
    output logic                mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_req_ready,
    input  logic                mem_rsp_valid,
    input  cache_pkg::mem_rsp_t mem_rsp,
    output logic                mem_rsp_ready
);

    cache_pkg::cache_state_e         state;
    cache_pkg::arb_req_t             req_q;
    cache_pkg::word_t                rsp_data;
    // Read request already taken by memory
    logic                            mem_sent;

    logic [5:0]                      tag_arr [cache_pkg::NUM_LINES];
    logic [cache_pkg::NUM_LINES-1:0] valid_arr;
    cache_pkg::line_t                data_arr [cache_pkg::NUM_LINES];

    logic [5:0]                      addr_tag;
    logic [3:0]                      idx;
    logic [1:0]                      woff;
    logic                            hit;
    logic                            fill;
    cache_pkg::line_byteen_t         wr_be;
    cache_pkg::line_t                wr_data;
    cache_pkg::line_t                wr_mask;

    function automatic cache_pkg::word_t word_of(cache_pkg::line_t line, logic [1:0] off);
        return cache_pkg::word_t'(line >> {off, 5'b0});
    endfunction

    assign {addr_tag, idx, woff} = req_q.addr;
    assign hit  = valid_arr[idx] && (tag_arr[idx] == addr_tag);
    assign fill = mem_rsp_valid && mem_rsp_ready;

    // Word and its byte enables moved to their slot in the line
    assign wr_be   = cache_pkg::line_byteen_t'(req_q.byteen) << {woff, 2'b0};
    assign wr_data = cache_pkg::line_t'(req_q.data) << {woff, 5'b0};

    always_comb begin
        for (int i = 0; i < cache_pkg::LINE_WORDS * 4; i++) begin
            wr_mask[i*8 +: 8] = {8{wr_be[i]}};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= cache_pkg::IDLE;
            mem_sent  <= 1'b0;
            valid_arr <= '0;
        end else begin
            case (state)
                cache_pkg::IDLE: begin
                    if (req_valid) begin
                        state <= cache_pkg::LOOKUP;
                    end
                end
                cache_pkg::LOOKUP: begin
                    if (req_q.rw) begin
                        state <= cache_pkg::MEM_WRITE;
                    end else if (hit) begin
                        state <= cache_pkg::RESPOND;
                    end else begin
                        state <= cache_pkg::MEM_READ;
                    end
                end
                cache_pkg::MEM_WRITE: begin
                    // Write-through ends once memory takes the word
                    if (mem_req_ready) begin
                        state <= cache_pkg::IDLE;
                    end
                end
                cache_pkg::MEM_READ: begin
                    if (mem_req_valid && mem_req_ready) begin
                        mem_sent <= 1'b1;
                    end
                    if (fill) begin
                        valid_arr[idx] <= 1'b1;
                        mem_sent       <= 1'b0;
                        state          <= cache_pkg::RESPOND;
                    end
                end
                cache_pkg::RESPOND: begin
                    if (rsp_ready) begin
                        state <= cache_pkg::IDLE;
                    end
                end
                default: state <= cache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            req_q <= req;
        end
        if (state == cache_pkg::LOOKUP && hit) begin
            rsp_data <= word_of(data_arr[idx], woff);
        end else if (fill) begin
            rsp_data <= word_of(mem_rsp.data, woff);
        end
    end

    // Write hit merges bytes, read miss fills the whole line
    always_ff @(posedge clk) begin
        if (state == cache_pkg::LOOKUP && req_q.rw && hit) begin
            data_arr[idx] <= (data_arr[idx] & ~wr_mask) | (wr_data & wr_mask);
        end else if (fill) begin
            data_arr[idx] <= mem_rsp.data;
            tag_arr[idx]  <= addr_tag;
        end
    end

    assign req_ready     = (state == cache_pkg::IDLE);
    assign rsp_valid     = (state == cache_pkg::RESPOND);
    assign rsp.data      = rsp_data;
    assign rsp.tag       = req_q.tag;
    assign mem_req_valid = (state == cache_pkg::MEM_WRITE) ||
                           (state == cache_pkg::MEM_READ && !mem_sent);
    assign mem_rsp_ready = (state == cache_pkg::MEM_READ);

    always_comb begin
        mem_req.rw     = (state == cache_pkg::MEM_WRITE);
        mem_req.byteen = mem_req.rw ? wr_be : '1;
        mem_req.addr   = {addr_tag, idx};
        mem_req.data   = wr_data;
        // Unit index is filled in by the memory arbiter
        mem_req.tag    = '0;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp));

    // Memory may only answer a read this unit is waiting on
    assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> state == cache_pkg::MEM_READ);

endmodule

/* logic/core_arb.sv */
module core_arb (
    input  logic                                             clk,
    input  logic                                             rst_n,
    input  logic [cache_pkg::NUM_INPUTS-1:0]                 core_req_valid,
    input  cache_pkg::core_req_t [cache_pkg::NUM_INPUTS-1:0] core_req,
    output logic [cache_pkg::NUM_INPUTS-1:0]                 core_req_ready,
    output logic [cache_pkg::NUM_INPUTS-1:0]                 core_rsp_valid,
    output cache_pkg::core_rsp_t [cache_pkg::NUM_INPUTS-1:0] core_rsp,
    input  logic [cache_pkg::NUM_INPUTS-1:0]                 core_rsp_ready,
    output logic [cache_pkg::NUM_CACHES-1:0]                 arb_req_valid,
    output cache_pkg::arb_req_t [cache_pkg::NUM_CACHES-1:0]  arb_req,
    input  logic [cache_pkg::NUM_CACHES-1:0]                 arb_req_ready,
    input  logic [cache_pkg::NUM_CACHES-1:0]                 arb_rsp_valid,
    input  cache_pkg::arb_rsp_t [cache_pkg::NUM_CACHES-1:0]  arb_rsp,
    output logic [cache_pkg::NUM_CACHES-1:0]                 arb_rsp_ready
);

    for (genvar u = 0; u < cache_pkg::NUM_CACHES; u++) begin : g_unit
        logic [cache_pkg::INPUTS_PER_CACHE-1:0] valids;
        logic                                   rr_ptr;
        logic                                   win;
        logic                                   stage_free;
        logic                                   accept;
        logic                                   stage_valid;
        cache_pkg::arb_req_t                    stage_req;
        cache_pkg::core_req_t                   src;
        logic                                   rsp_port;

        assign valids = core_req_valid[u*cache_pkg::INPUTS_PER_CACHE +:
                                       cache_pkg::INPUTS_PER_CACHE];

        // Stage can take a new request if empty or emptied on this edge
        assign stage_free = !stage_valid || arb_req_ready[u];

        // Favored port wins when it asks, otherwise the other one
        assign win    = valids[rr_ptr] ? rr_ptr : !rr_ptr;
        assign accept = valids[win] && stage_free;
        assign src    = win ? core_req[u*cache_pkg::INPUTS_PER_CACHE + 1]
                            : core_req[u*cache_pkg::INPUTS_PER_CACHE];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                stage_valid <= 1'b0;
                rr_ptr      <= 1'b0;
            end else if (accept) begin
                stage_valid <= 1'b1;
                rr_ptr      <= !win;
            end else if (arb_req_ready[u]) begin
                stage_valid <= 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (accept) begin
                stage_req <= '{rw:     src.rw,
                               byteen: src.byteen,
                               addr:   src.addr,
                               data:   src.data,
                               tag:    {win, src.tag}};
            end
        end

        assign arb_req_valid[u] = stage_valid;
        assign arb_req[u]       = stage_req;

        // Top tag bit picks the port inside this unit
        assign rsp_port         = arb_rsp[u].tag[$bits(cache_pkg::arb_tag_t)-1];
        assign arb_rsp_ready[u] = rsp_port ? core_rsp_ready[u*cache_pkg::INPUTS_PER_CACHE + 1]
                                           : core_rsp_ready[u*cache_pkg::INPUTS_PER_CACHE];

        for (genvar j = 0; j < cache_pkg::INPUTS_PER_CACHE; j++) begin : g_port
            assign core_req_ready[u*cache_pkg::INPUTS_PER_CACHE + j] =
                stage_free && (win == 1'(j));
            assign core_rsp_valid[u*cache_pkg::INPUTS_PER_CACHE + j] =
                arb_rsp_valid[u] && (rsp_port == 1'(j));
            assign core_rsp[u*cache_pkg::INPUTS_PER_CACHE + j] =
                '{data: arb_rsp[u].data,
                  tag:  cache_pkg::core_tag_t'(arb_rsp[u].tag)};
        end

        // Stalled stage holds its request unchanged
        assert property (@(posedge clk) disable iff (!rst_n)
            arb_req_valid[u] && !arb_req_ready[u] |=>
                arb_req_valid[u] && $stable(arb_req[u]));
    end

endmodule

/* logic/mem_arb.sv */
module mem_arb (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic [cache_pkg::NUM_CACHES-1:0]                req_valid,
    input  cache_pkg::mem_req_t [cache_pkg::NUM_CACHES-1:0] req,
    output logic [cache_pkg::NUM_CACHES-1:0]                req_ready,
    output logic [cache_pkg::NUM_CACHES-1:0]                rsp_valid,
    output cache_pkg::mem_rsp_t [cache_pkg::NUM_CACHES-1:0] rsp,
    input  logic [cache_pkg::NUM_CACHES-1:0]                rsp_ready,
    output logic                                            mem_req_valid,
    output cache_pkg::mem_req_t                             mem_req,
    input  logic                                            mem_req_ready,
    input  logic                                            mem_rsp_valid,
    input  cache_pkg::mem_rsp_t                             mem_rsp,
    output logic                                            mem_rsp_ready
);

    cache_pkg::unit_sel_t            rr_ptr;
    cache_pkg::unit_sel_t            lock_sel;
    logic                            locked;
    cache_pkg::unit_sel_t            grant;
    logic                            req_fire;
    logic                            rsp_fire;
    logic [cache_pkg::NUM_CACHES-1:0] rd_pending;

    // A waiting unit keeps the port until its transfer completes
    always_comb begin
        if (locked) begin
            grant = lock_sel;
        end else if (req_valid[rr_ptr]) begin
            grant = rr_ptr;
        end else begin
            grant = ~rr_ptr;
        end
    end

    assign mem_req_valid = req_valid[grant];
    assign req_fire      = mem_req_valid && mem_req_ready;
    assign rsp_fire      = mem_rsp_valid && mem_rsp_ready;
    assign mem_rsp_ready = rsp_ready[mem_rsp.tag];

    always_comb begin
        mem_req     = req[grant];
        mem_req.tag = grant;
    end

    for (genvar u = 0; u < cache_pkg::NUM_CACHES; u++) begin : g_unit
        assign req_ready[u] = mem_req_ready && (grant == 1'(u));
        assign rsp_valid[u] = mem_rsp_valid && (mem_rsp.tag == 1'(u));
        assign rsp[u]       = mem_rsp;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rr_ptr     <= '0;
            lock_sel   <= '0;
            locked     <= 1'b0;
            rd_pending <= '0;
        end else begin
            if (req_fire) begin
                locked <= 1'b0;
                rr_ptr <= ~grant;
            end else if (mem_req_valid && !locked) begin
                locked   <= 1'b1;
                lock_sel <= grant;
            end
            if (rsp_fire) begin
                rd_pending[mem_rsp.tag] <= 1'b0;
            end
            if (req_fire && !mem_req.rw) begin
                rd_pending[grant] <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_rsp_valid |-> rd_pending[mem_rsp.tag]);

endmodule

/* tests/mem_model.sv */
module mem_model (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mem_req_valid,
    input  cache_pkg::mem_req_t mem_req,
    output logic                mem_req_ready,
    output logic                mem_rsp_valid,
    output cache_pkg::mem_rsp_t mem_rsp,
    input  logic                mem_rsp_ready
);

    typedef struct packed {
        cache_pkg::line_t     data;
        cache_pkg::unit_sel_t tag;
        int                   due;
    } pending_t;

    cache_pkg::word_t mem [4096];
    pending_t         rsp_q [$];
    int               cycle;

    // Every word starts with a value tied to its full address
    initial begin
        for (int a = 0; a < 4096; a++) begin
            mem[a] = (cache_pkg::word_t'(a) * 32'h01010101) ^ 32'hA5A5A5A5;
        end
    end

    // Writes land at once, reads capture the line at acceptance
    task automatic accept_request(input cache_pkg::mem_req_t r);
        pending_t ent;
        int       base;
        base = 4 * int'(r.addr);
        for (int k = 0; k < cache_pkg::LINE_WORDS; k++) begin
            for (int b = 0; b < 4; b++) begin
                if (r.rw && r.byteen[k*4 + b]) begin
                    mem[base + k][b*8 +: 8] = r.data[k*32 + b*8 +: 8];
                end
            end
            ent.data[k*32 +: 32] = mem[base + k];
        end
        if (!r.rw) begin
            ent.tag = r.tag;
            ent.due = cycle + int'($urandom_range(1, 6));
            rsp_q.push_back(ent);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_req_ready <= 1'b0;
            mem_rsp_valid <= 1'b0;
            mem_rsp       <= '0;
            cycle         <= 0;
        end else begin
            cycle <= cycle + 1;
            if (mem_req_valid && mem_req_ready) begin
                accept_request(mem_req);
            end
            if (mem_rsp_valid && mem_rsp_ready) begin
                rsp_q.delete(0);
            end
            // Responses leave in order once due
            if (!mem_rsp_valid || mem_rsp_ready) begin
                if (rsp_q.size() > 0 && rsp_q[0].due <= cycle) begin
                    mem_rsp_valid <= 1'b1;
                    mem_rsp       <= '{data: rsp_q[0].data, tag: rsp_q[0].tag};
                end else begin
                    mem_rsp_valid <= 1'b0;
                end
            end
            mem_req_ready <= ($urandom_range(3) != 0);
        end
    end

endmodule

/* tests/tb_cache_cluster.sv */
module tb_cache_cluster;

    localparam int          REQS_PER_PORT = 40;
    localparam int          TOTAL_REQS    = 2 + 2 * cache_pkg::NUM_INPUTS * REQS_PER_PORT;
    localparam int          LIMIT_CYCLES  = 16 + 200 * TOTAL_REQS;
    localparam logic [11:0] DIRECTED_ADDR = 12'h0A6;

    typedef struct packed {
        cache_pkg::core_tag_t tag;
        cache_pkg::word_t     data;
    } read_exp_t;

    typedef struct packed {
        cache_pkg::line_addr_t   addr;
        cache_pkg::line_byteen_t byteen;
        cache_pkg::line_t        data;
    } write_exp_t;

    logic                                             clk   = 1'b0;
    logic                                             rst_n = 1'b0;
    logic [cache_pkg::NUM_INPUTS-1:0]                 core_req_valid = '0;
    cache_pkg::core_req_t [cache_pkg::NUM_INPUTS-1:0] core_req       = '0;
    logic [cache_pkg::NUM_INPUTS-1:0]                 core_req_ready;
    logic [cache_pkg::NUM_INPUTS-1:0]                 core_rsp_valid;
    cache_pkg::core_rsp_t [cache_pkg::NUM_INPUTS-1:0] core_rsp;
    logic [cache_pkg::NUM_INPUTS-1:0]                 core_rsp_ready = '0;
    logic                                             mem_req_valid;
    cache_pkg::mem_req_t                              mem_req;
    logic                                             mem_req_ready;
    logic                                             mem_rsp_valid;
    cache_pkg::mem_rsp_t                              mem_rsp;
    logic                                             mem_rsp_ready;

    // Phase controls change between phases on the falling edge
    int   phase     = 0;
    int   go_pct    = 100;
    int   rsp_pct   = 100;
    logic serialize = 1'b1;

    // Reference model state
    int                               phase_seen = 0;
    int                               done_phase = 0;
    int                               left [cache_pkg::NUM_INPUTS] = '{default: 0};
    logic [5:0]                       seq  [cache_pkg::NUM_INPUTS] = '{default: '0};
    logic [cache_pkg::NUM_INPUTS-1:0] busy = '0;
    read_exp_t                        exp_q [cache_pkg::NUM_INPUTS][$];
    write_exp_t                       wr_exp [$];
    cache_pkg::word_t                 shadow [4096];
    int                               cycle       = 0;
    int                               mem_reads   = 0;
    int                               last_accept = 0;
    int                               last_rsp    = 0;

    cache_cluster dut0 (
        .clk            (clk),
        .rst_n          (rst_n),
        .core_req_valid (core_req_valid),
        .core_req       (core_req),
        .core_req_ready (core_req_ready),
        .core_rsp_valid (core_rsp_valid),
        .core_rsp       (core_rsp),
        .core_rsp_ready (core_rsp_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req),
        .mem_req_ready  (mem_req_ready),
        .mem_rsp_valid  (mem_rsp_valid),
        .mem_rsp        (mem_rsp),
        .mem_rsp_ready  (mem_rsp_ready)
    );

    mem_model mem0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp       (mem_rsp),
        .mem_rsp_ready (mem_rsp_ready)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("Fail at time %0t: %s expected %0h, got %0h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic all_drained();
        logic ok;
        ok = (wr_exp.size() == 0);
        for (int p = 0; p < cache_pkg::NUM_INPUTS; p++) begin
            if (left[p] != 0 || busy[p] || exp_q[p].size() != 0) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    // Each port stays inside its own quarter of the address space
    function automatic cache_pkg::core_req_t make_request(input int p);
        cache_pkg::core_req_t r;
        r.tag  = {2'(p), seq[p]};
        seq[p] = seq[p] + 6'd1;
        if (phase == 1) begin
            r.rw     = 1'b0;
            r.byteen = 4'hF;
            r.addr   = DIRECTED_ADDR;
            r.data   = '0;
        end else begin
            r.rw     = ($urandom_range(2) == 0);
            r.byteen = 4'($urandom_range(1, 15));
            r.addr   = {2'(p), 10'($urandom_range(95))};
            r.data   = $urandom;
        end
        return r;
    endfunction

    // Shadow memory and expectations move when the port hands a request over
    task automatic record_issue(input int p, input cache_pkg::core_req_t r);
        read_exp_t  e;
        write_exp_t w;
        if (r.rw) begin
            for (int b = 0; b < 4; b++) begin
                if (r.byteen[b]) begin
                    shadow[r.addr][b*8 +: 8] = r.data[b*8 +: 8];
                end
            end
            w.addr   = r.addr[11:2];
            w.byteen = '0;
            w.data   = '0;
            for (int k = 0; k < cache_pkg::LINE_WORDS; k++) begin
                if (r.addr[1:0] == 2'(k)) begin
                    w.byteen[k*4 +: 4]  = r.byteen;
                    w.data[k*32 +: 32]  = r.data;
                end
            end
            wr_exp.push_back(w);
        end else begin
            e.tag  = r.tag;
            e.data = shadow[r.addr];
            exp_q[p].push_back(e);
        end
        if (p == 0) begin
            last_accept = cycle;
        end
    endtask

    task automatic service_port(input int p, output logic valid_nxt,
                                output cache_pkg::core_req_t req_nxt, output logic ready_nxt);
        read_exp_t e;
        valid_nxt = core_req_valid[p];
        req_nxt   = core_req[p];
        if (core_req_valid[p] && core_req_ready[p]) begin
            record_issue(p, core_req[p]);
            valid_nxt = 1'b0;
        end
        if (!valid_nxt && left[p] > 0 && (!serialize || exp_q[p].size() == 0) &&
            $urandom_range(99) < go_pct) begin
            req_nxt   = make_request(p);
            valid_nxt = 1'b1;
            left[p]   = left[p] - 1;
        end
        if (core_rsp_valid[p] && core_rsp_ready[p]) begin
            if (exp_q[p].size() == 0) begin
                fail_run($sformatf("Port %0d got a response with no read outstanding", p));
            end else begin
                e = exp_q[p].pop_front();
                check_value($sformatf("core_rsp[%0d].tag", p), 128'(e.tag),
                            128'(core_rsp[p].tag));
                check_value($sformatf("core_rsp[%0d].data", p), 128'(e.data),
                            128'(core_rsp[p].data));
                if (p == 0) begin
                    last_rsp = cycle;
                end
            end
        end
        ready_nxt = ($urandom_range(99) < rsp_pct);
    endtask

    // Same line address means same port, so the oldest match is the one
    task automatic watch_memory();
        int               found;
        write_exp_t       w;
        cache_pkg::line_t mask;
        found = -1;
        if (mem_req_valid && mem_req_ready) begin
            if (!mem_req.rw) begin
                mem_reads = mem_reads + 1;
            end else begin
                for (int i = 0; i < wr_exp.size(); i++) begin
                    if (found < 0 && wr_exp[i].addr == mem_req.addr) begin
                        found = i;
                    end
                end
                if (found < 0) begin
                    fail_run($sformatf("Memory write to line %0h matches no core write",
                                       mem_req.addr));
                end else begin
                    w = wr_exp[found];
                    wr_exp.delete(found);
                    for (int i = 0; i < cache_pkg::LINE_WORDS * 4; i++) begin
                        mask[i*8 +: 8] = {8{w.byteen[i]}};
                    end
                    check_value("mem_req.byteen", 128'(w.byteen), 128'(mem_req.byteen));
                    check_value("mem_req.data", w.data & mask, mem_req.data & mask);
                end
            end
        end
    endtask

    always @(posedge clk) begin
        logic                 v;
        logic                 rd;
        cache_pkg::core_req_t r;
        if (rst_n) begin
            cycle = cycle + 1;
            if (phase != phase_seen) begin
                phase_seen = phase;
                for (int p = 0; p < cache_pkg::NUM_INPUTS; p++) begin
                    left[p] = (phase == 1) ? ((p == 0) ? 2 : 0) : REQS_PER_PORT;
                end
            end
            for (int p = 0; p < cache_pkg::NUM_INPUTS; p++) begin
                service_port(p, v, r, rd);
                busy[p]           = v;
                core_req_valid[p] <= v;
                core_req[p]       <= r;
                core_rsp_ready[p] <= rd;
            end
            watch_memory();
            if (all_drained()) begin
                done_phase <= phase;
            end
        end
    end

    task automatic run_phase(input int id, input int go, input int rsp, input logic one_at_a_time);
        @(negedge clk);
        go_pct    = go;
        rsp_pct   = rsp;
        serialize = one_at_a_time;
        phase     = id;
        while (done_phase != id) begin
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    initial begin
        repeat (LIMIT_CYCLES) @(posedge clk);
        fail_run($sformatf("Timeout after %0d cycles, the DUT stopped making progress",
                           LIMIT_CYCLES));
    end

    initial begin
        int reads_before;
        void'($urandom(75));
        for (int a = 0; a < 4096; a++) begin
            shadow[a] = (cache_pkg::word_t'(a) * 32'h01010101) ^ 32'hA5A5A5A5;
        end
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // Cold read then a repeat of it that hits
        @(negedge clk);
        reads_before = mem_reads;
        run_phase(1, 100, 100, 1'b1);
        check_value("memory read count", 128'(1), 128'(mem_reads - reads_before));
        check_value("read hit latency", 128'(3), 128'(last_rsp - last_accept));

        // Random traffic under light then heavy back-pressure
        run_phase(2, 70, 90, 1'b0);
        run_phase(3, 50, 40, 1'b0);

        // DUT must be idle once every expected response and write has arrived
        if (all_drained() && core_rsp_valid == '0 && !mem_req_valid) begin
            $display("Testbench passed");
            $finish;
        end else begin
            fail_run("Responses, memory requests or expected traffic are still pending at the end");
        end
    end

endmodule
